// File: div_vectors.txt
# fmt op vectorial mask operand_a operand_b exp_result exp_status (all hex)
# fmt 0=W32 1=W16, op 0=div 1=rem, status bit1=dz bit0=nx
0 0 0 3 00000064 00000007 0000000E 1
0 1 0 3 00000064 00000007 00000002 1
0 0 0 1 FFFFFFFF 0000FFFF 00010001 0
0 1 0 1 FFFFFFFF 0000FFFF 00000000 0
0 0 0 1 80000000 00000003 2AAAAAAA 1
0 0 0 1 DEADBEEF 00000010 0DEADBEE 1
0 1 0 1 DEADBEEF 00000010 0000000F 1
0 0 0 1 12345678 00000000 FFFFFFFF 2
0 1 0 1 12345678 00000000 12345678 2
0 0 0 2 00000064 00000007 0000000E 0
1 0 1 3 03E80064 0007000A 008E000A 1
1 1 1 3 03E80064 0007000A 00060000 1
1 0 1 3 ABCD00FF 00000010 FFFF000F 3
1 1 1 3 ABCD00FF 00000010 ABCD000F 3
1 0 1 1 ABCD00FF 00000010 FFFF000F 1
1 0 0 3 12340064 00000007 FFFF000E 1
1 1 0 3 5555FFFF 99990100 FFFF00FF 1
1 0 0 3 00001234 FFFF0000 FFFFFFFF 2
1 1 0 3 00001234 FFFF0000 FFFF1234 2
1 0 1 0 00640064 00070007 000E000E 0
1 1 1 2 00640064 000A0007 00000002 0

// File: src.f
simd_fmt_pkg.sv
div_flags_pkg.sv
divslice_ctrl_fsm.sv
div_iter_timer.sv
div_lane.sv
divslice_result_pack.sv
simd_div_slice.sv
div_checker.sv
tb_simd_div_slice.sv

// File: Makefile
# Verilator build and run of the SIMD divide slice testbench

TOP := tb_simd_div_slice

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qF "** PASS **" sim.log

obj_dir/V$(TOP): src.f $(wildcard *.sv) div_vectors.txt
	verilator --binary -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only -Wall -f src.f --top-module $(TOP)
	verilator --lint-only -Wall simd_fmt_pkg.sv div_flags_pkg.sv divslice_ctrl_fsm.sv \
	  div_iter_timer.sv div_lane.sv divslice_result_pack.sv simd_div_slice.sv \
	  --top-module simd_div_slice

clean:
	rm -rf obj_dir sim.log

// File: tb_simd_div_slice.sv
/*
 * Testbench top of the SIMD divide slice
 * Clock, reset, vector-file stimulus, random output stall
 * and the final verdict
 */

`timescale 1ns/100ps

module tb_simd_div_slice;

  import simd_fmt_pkg::*;
  import div_flags_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int TIMEOUT_CYC = 100;

  logic                  clk = 1'b0;
  logic                  arst_n = 1'b1;
  logic [DATA_WIDTH-1:0] operand_a;
  logic [DATA_WIDTH-1:0] operand_b;
  fmt_e                  fmt;
  op_e                   op;
  logic                  vectorial;
  lane_mask_t            simd_mask;
  logic [3:0]            tag;
  logic                  in_valid;
  logic                  in_ready;
  logic [DATA_WIDTH-1:0] result;
  div_flags_t            status;
  logic [3:0]            tag_out;
  logic                  out_valid;
  logic                  out_ready = 1'b0;
  logic                  busy;
  logic [DATA_WIDTH-1:0] exp_result;
  logic [1:0]            exp_status;
  int                    tests;
  int                    errors;
  int                    sent;
  integer                seed = 32'h19b8;

  always #(CLK_PERIOD/2) clk = ~clk;

  // Output side stalls about one cycle in four
  always @(negedge clk) begin
    if (!arst_n) begin
      out_ready <= 1'b0;
    end else begin
      out_ready <= (($random(seed) & 3) != 0);
    end
  end

  simd_div_slice #(
    .TagType ( logic [3:0] )
  ) i_simd_div_slice (
    .clk_i          ( clk        ),
    .arst_n_i       ( arst_n     ),
    .operand_a_i    ( operand_a  ),
    .operand_b_i    ( operand_b  ),
    .fmt_i          ( fmt        ),
    .op_i           ( op         ),
    .vectorial_op_i ( vectorial  ),
    .simd_mask_i    ( simd_mask  ),
    .tag_i          ( tag        ),
    .in_valid_i     ( in_valid   ),
    .in_ready_o     ( in_ready   ),
    .result_o       ( result     ),
    .status_o       ( status     ),
    .tag_o          ( tag_out    ),
    .out_valid_o    ( out_valid  ),
    .out_ready_i    ( out_ready  ),
    .busy_o         ( busy       )
  );

  div_checker i_div_checker (
    .clk_i        ( clk        ),
    .arst_n_i     ( arst_n     ),
    .operand_a_i  ( operand_a  ),
    .operand_b_i  ( operand_b  ),
    .fmt_i        ( fmt        ),
    .op_i         ( op         ),
    .vectorial_i  ( vectorial  ),
    .mask_i       ( simd_mask  ),
    .tag_i        ( tag        ),
    .in_valid_i   ( in_valid   ),
    .in_ready_i   ( in_ready   ),
    .result_i     ( result     ),
    .status_i     ( status     ),
    .tag_out_i    ( tag_out    ),
    .out_valid_i  ( out_valid  ),
    .out_ready_i  ( out_ready  ),
    .busy_i       ( busy       ),
    .exp_result_i ( exp_result ),
    .exp_status_i ( exp_status ),
    .tests_o      ( tests      ),
    .errors_o     ( errors     )
  );

  // Drive one operation, wait for its result and for the slice to drain
  task automatic send_operation(input logic [31:0] f, o, v, m, a, b, er, es, input int idx,
                                output bit ok);
    int wait_cyc;
    ok         = 1'b0;
    operand_a  = a;
    operand_b  = b;
    fmt        = fmt_e'(f[0]);
    op         = op_e'(o[0]);
    vectorial  = v[0];
    simd_mask  = m[1:0];
    tag        = idx[3:0];
    exp_result = er;
    exp_status = es[1:0];
    in_valid   = 1'b1;
    wait_cyc   = 0;
    while (!in_ready) begin
      @(negedge clk);
      wait_cyc++;
      if (wait_cyc > TIMEOUT_CYC) begin
        $display("%0t: timeout waiting for in_ready_o", $time);
        in_valid = 1'b0;
        return;
      end
    end
    // Accepted on the rising edge in between
    @(negedge clk);
    in_valid = 1'b0;
    wait_cyc = 0;
    while (!out_valid) begin
      @(negedge clk);
      wait_cyc++;
      if (wait_cyc > TIMEOUT_CYC) begin
        $display("%0t: timeout waiting for out_valid_o", $time);
        return;
      end
    end
    wait_cyc = 0;
    while (!in_ready) begin
      @(negedge clk);
      wait_cyc++;
      if (wait_cyc > TIMEOUT_CYC) begin
        $display("%0t: result was never taken, slice stays busy", $time);
        return;
      end
    end
    ok = 1'b1;
  endtask

  initial begin
    string       line;
    int          fd;
    int          n;
    logic [31:0] col [8];
    bit          ok;
    operand_a  = '0;
    operand_b  = '0;
    fmt        = FMT_W32;
    op         = OP_DIV;
    vectorial  = 1'b0;
    simd_mask  = '0;
    tag        = '0;
    in_valid   = 1'b0;
    exp_result = '0;
    exp_status = '0;
    sent       = 0;
    #1 arst_n = 1'b0;
    fd = $fopen("div_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open div_vectors.txt");
    end
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    ok = (fd != 0);
    while (ok && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line[0] == "#") continue;
      if ($sscanf(line, "%h %h %h %h %h %h %h %h", col[0], col[1], col[2], col[3],
                  col[4], col[5], col[6], col[7]) != 8) continue;
      send_operation(col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                     sent, ok);
      sent++;
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    repeat (2) @(negedge clk);
    $display("sent %0d, checked %0d, errors %0d", sent, tests, errors);
    if (ok && errors == 0 && tests == sent && sent > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: div_checker.sv
/*
 * Checker of the SIMD divide slice testbench
 * Captures accepted operations, checks latency, busy, output hold
 * under stall, and result, status and tag of each test
 */

`timescale 1ns/100ps

module div_checker (
  input  logic                                clk_i,
  input  logic                                arst_n_i,
  input  logic [simd_fmt_pkg::DATA_WIDTH-1:0] operand_a_i,
  input  logic [simd_fmt_pkg::DATA_WIDTH-1:0] operand_b_i,
  input  simd_fmt_pkg::fmt_e                  fmt_i,
  input  simd_fmt_pkg::op_e                   op_i,
  input  logic                                vectorial_i,
  input  simd_fmt_pkg::lane_mask_t            mask_i,
  input  logic [3:0]                          tag_i,
  input  logic                                in_valid_i,
  input  logic                                in_ready_i,
  input  logic [simd_fmt_pkg::DATA_WIDTH-1:0] result_i,
  input  div_flags_pkg::div_flags_t           status_i,
  input  logic [3:0]                          tag_out_i,
  input  logic                                out_valid_i,
  input  logic                                out_ready_i,
  input  logic                                busy_i,
  input  logic [simd_fmt_pkg::DATA_WIDTH-1:0] exp_result_i,
  input  logic [1:0]                          exp_status_i,
  output int                                  tests_o,
  output int                                  errors_o
);

  import simd_fmt_pkg::*;
  import div_flags_pkg::*;

  int          tests = 0;
  int          errors = 0;
  int          errors_at_start = 0;
  int          cyc = 0;
  int          latency;
  logic        pending = 1'b0;
  logic        seen_valid = 1'b0;
  logic        hold_chk = 1'b0;
  fmt_e        fmt_q;
  logic [31:0] exp_res_q;
  logic [1:0]  exp_st_q;
  logic [3:0]  tag_q;
  logic [31:0] held_res;
  div_flags_t  held_st;
  logic [3:0]  held_tag;

  assign tests_o  = tests;
  assign errors_o = errors;

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Integer division per element, returns {dz, nx, result}
  function automatic logic [33:0] model_result(input fmt_e f, input op_e o, input logic vec,
                                               input lane_mask_t m, input logic [31:0] a,
                                               input logic [31:0] b);
    logic [31:0] res;
    logic [1:0]  st;
    logic [31:0] ea;
    logic [31:0] eb;
    logic [31:0] q;
    logic [31:0] r;
    logic [31:0] val;
    res = '1;
    st  = '0;
    for (int l = 0; l < ((f == FMT_W16) ? 2 : 1); l++) begin
      if (l == 0 || vec) begin
        ea = (f == FMT_W16) ? 32'(a[16*l +: 16]) : a;
        eb = (f == FMT_W16) ? 32'(b[16*l +: 16]) : b;
        if (eb == 0) begin
          q = '1;
          r = ea;
        end else begin
          q = ea / eb;
          r = ea % eb;
        end
        val = (o == OP_DIV) ? q : r;
        if (f == FMT_W16) res[16*l +: 16] = val[15:0];
        else res = val;
        if (m[l]) st = st | {eb == 0, (eb != 0) && (r != 0)};
      end
    end
    return {st, res};
  endfunction

  always @(posedge clk_i) begin
    logic [33:0] model;
    if (!arst_n_i) begin
      if (!in_ready_i || out_valid_i || busy_i) begin
        errors++;
        $display("%0t: handshake outputs not at their reset values", $time);
      end
    end else begin
      // Busy from acceptance until the result leaves
      compare_value("busy_o", 32'(pending), 32'(busy_i));

      // Outputs must not move while the result is stalled
      if (hold_chk) begin
        compare_value("result_o", held_res, result_i);
        compare_value("status_o", 32'(held_st), 32'(status_i));
        compare_value("tag_o", 32'(held_tag), 32'(tag_out_i));
        if (in_ready_i) begin
          errors++;
          $display("%0t: in_ready_o high while a result is stalled", $time);
        end
      end
      hold_chk = out_valid_i && !out_ready_i;
      held_res = result_i;
      held_st  = status_i;
      held_tag = tag_out_i;

      if (pending) begin
        cyc++;
        if (out_valid_i && !seen_valid) begin
          seen_valid = 1'b1;
          latency = (fmt_q == FMT_W16) ? FMT_W16_BITS + 1 : FMT_W32_BITS + 1;
          if (cyc - 1 != latency) begin
            errors++;
            $display("%0t: out_valid_o rose %0d cycles after acceptance, %0d expected",
                     $time, cyc - 1, latency);
          end
        end
        if (out_valid_i && out_ready_i) begin
          compare_value("result_o", exp_res_q, result_i);
          compare_value("status_o", 32'(exp_st_q), 32'(status_i));
          compare_value("tag_o", 32'(tag_q), 32'(tag_out_i));
          tests++;
          if (errors == errors_at_start) $display("test %0d (tag %h) passed", tests, tag_q);
          else $display("test %0d (tag %h) failed", tests, tag_q);
          pending = 1'b0;
        end
      end

      if (in_valid_i && in_ready_i) begin
        if (pending) begin
          errors++;
          $display("%0t: new operation accepted while one is in flight", $time);
        end
        errors_at_start = errors;
        pending    = 1'b1;
        seen_valid = 1'b0;
        cyc        = 0;
        fmt_q      = fmt_i;
        exp_res_q  = exp_result_i;
        exp_st_q   = exp_status_i;
        tag_q      = tag_i;
        model = model_result(fmt_i, op_i, vectorial_i, mask_i, operand_a_i, operand_b_i);
        if (model !== {exp_status_i, exp_result_i}) begin
          errors++;
          $display("%0t: vector with tag %h disagrees with the reference model", $time, tag_i);
        end
      end
    end
  end

endmodule

// File: simd_div_slice.sv
/*
 * Two-lane SIMD integer divide slice
 * Control FSM, iteration timer, one 32-bit and one 16-bit
 * divide lane, and the result packer
 */

`timescale 1ns/100ps

module simd_div_slice #(
  parameter type TagType = logic [3:0]
) (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  logic [simd_fmt_pkg::DATA_WIDTH-1:0]  operand_a_i,
  input  logic [simd_fmt_pkg::DATA_WIDTH-1:0]  operand_b_i,
  input  simd_fmt_pkg::fmt_e                   fmt_i,
  input  simd_fmt_pkg::op_e                    op_i,
  input  logic                                 vectorial_op_i,
  input  simd_fmt_pkg::lane_mask_t             simd_mask_i,
  input  TagType                               tag_i,
  input  logic                                 in_valid_i,
  output logic                                 in_ready_o,
  output logic [simd_fmt_pkg::DATA_WIDTH-1:0]  result_o,
  output div_flags_pkg::div_flags_t            status_o,
  output TagType                               tag_o,
  output logic                                 out_valid_o,
  input  logic                                 out_ready_i,
  output logic                                 busy_o
);

  import simd_fmt_pkg::*;
  import div_flags_pkg::*;

  fmt_e                    fmt_q;
  op_e                     op_q;
  lane_mask_t              mask_q;
  lane_mask_t              lane_active;
  lane_mask_t              lane_start;
  logic                    timer_load;
  logic                    step;
  logic                    last;
  logic [FMT_W32_BITS-1:0] lane0_result;
  logic [FMT_W16_BITS-1:0] lane1_result;
  div_flags_t              lane0_flags;
  div_flags_t              lane1_flags;

  divslice_ctrl_fsm #(
    .TagType ( TagType )
  ) i_ctrl_fsm (
    .clk_i, .arst_n_i, .in_valid_i, .out_ready_i, .fmt_i, .op_i,
    .vectorial_op_i, .simd_mask_i, .tag_i,
    .last_i        ( last        ),
    .in_ready_o, .out_valid_o, .busy_o, .tag_o,
    .fmt_q_o       ( fmt_q       ),
    .op_q_o        ( op_q        ),
    .mask_q_o      ( mask_q      ),
    .lane_active_o ( lane_active ),
    .lane_start_o  ( lane_start  ),
    .timer_load_o  ( timer_load  )
  );

  div_iter_timer i_iter_timer (
    .clk_i, .arst_n_i,
    .load_i ( timer_load ),
    .fmt_i  ( fmt_q      ),
    .step_o ( step       ),
    .last_o ( last       )
  );

  // --------------------------------------------------
  // Lanes, lane 1 sits on the upper half of the operands
  // --------------------------------------------------
  div_lane #(
    .LaneWidth ( FMT_W32_BITS )
  ) i_lane0 (
    .clk_i, .arst_n_i,
    .start_i    ( lane_start[0]                  ),
    .step_i     ( step                           ),
    .fmt_i      ( fmt_q                          ),
    .op_i       ( op_q                           ),
    .dividend_i ( operand_a_i[FMT_W32_BITS-1:0]  ),
    .divisor_i  ( operand_b_i[FMT_W32_BITS-1:0]  ),
    .result_o   ( lane0_result                   ),
    .flags_o    ( lane0_flags                    )
  );

  div_lane #(
    .LaneWidth ( FMT_W16_BITS )
  ) i_lane1 (
    .clk_i, .arst_n_i,
    .start_i    ( lane_start[1]                           ),
    .step_i     ( step                                    ),
    .fmt_i      ( fmt_q                                   ),
    .op_i       ( op_q                                    ),
    .dividend_i ( operand_a_i[DATA_WIDTH-1 -: FMT_W16_BITS] ),
    .divisor_i  ( operand_b_i[DATA_WIDTH-1 -: FMT_W16_BITS] ),
    .result_o   ( lane1_result                            ),
    .flags_o    ( lane1_flags                             )
  );

  divslice_result_pack i_result_pack (
    .fmt_i          ( fmt_q        ),
    .lane_active_i  ( lane_active  ),
    .mask_i         ( mask_q       ),
    .lane0_result_i ( lane0_result ),
    .lane1_result_i ( lane1_result ),
    .lane0_flags_i  ( lane0_flags  ),
    .lane1_flags_i  ( lane1_flags  ),
    .result_o,
    .status_o
  );

endmodule

// File: divslice_result_pack.sv
/*
 * Result packing of the SIMD divide slice
 * Lane results into the output word with boxing of unused lanes,
 * status collapse over active and masked-in lanes
 */

`timescale 1ns/100ps

module divslice_result_pack (
  input  simd_fmt_pkg::fmt_e                     fmt_i,
  input  simd_fmt_pkg::lane_mask_t               lane_active_i,
  input  simd_fmt_pkg::lane_mask_t               mask_i,
  input  logic [simd_fmt_pkg::FMT_W32_BITS-1:0]  lane0_result_i,
  input  logic [simd_fmt_pkg::FMT_W16_BITS-1:0]  lane1_result_i,
  input  div_flags_pkg::div_flags_t              lane0_flags_i,
  input  div_flags_pkg::div_flags_t              lane1_flags_i,
  output logic [simd_fmt_pkg::DATA_WIDTH-1:0]    result_o,
  output div_flags_pkg::div_flags_t              status_o
);

  import simd_fmt_pkg::*;
  import div_flags_pkg::*;

  div_flags_t                  lane_flags [NUM_LANES];
  logic [FMT_W16_BITS-1:0]     upper_half;

  assign lane_flags[0] = lane0_flags_i;
  assign lane_flags[1] = lane1_flags_i;

  // --------------------------------------------------
  // Result word
  // --------------------------------------------------
  assign upper_half = lane_active_i[1] ? lane1_result_i : BOX_FILL;

  always_comb begin
    if (fmt_i == FMT_W16) begin
      result_o = {upper_half, lane0_result_i[FMT_W16_BITS-1:0]};
    end else begin
      result_o = lane0_result_i;
    end
  end

  // --------------------------------------------------
  // Status collapse
  // --------------------------------------------------
  always_comb begin
    div_flags_t acc;
    acc = '0;
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      // Idle or masked-out lanes contribute nothing
      if (lane_active_i[l] && mask_i[l]) begin
        acc = acc | lane_flags[l];
      end
    end
    status_o = acc;
  end

endmodule

// File: div_lane.sv
/*
 * One lane of the SIMD divide slice
 * Unsigned restoring divider, one quotient bit per step,
 * quotient or remainder select and dz/nx flags
 */

`timescale 1ns/100ps

module div_lane #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      start_i,
  input  logic                      step_i,
  input  simd_fmt_pkg::fmt_e        fmt_i,
  input  simd_fmt_pkg::op_e         op_i,
  input  logic [LaneWidth-1:0]      dividend_i,
  input  logic [LaneWidth-1:0]      divisor_i,
  output logic [LaneWidth-1:0]      result_o,
  output div_flags_pkg::div_flags_t flags_o
);

  import simd_fmt_pkg::*;

  // Low element of the lane in FMT_W16
  localparam logic [LaneWidth-1:0] LowMask = {LaneWidth{1'b1}} >> (LaneWidth - FMT_W16_BITS);

  logic                 narrow;
  // Dividend shifts out at the top while quotient bits enter at the bottom
  logic [LaneWidth-1:0] dvd_q;
  logic [LaneWidth-1:0] rem_q;
  logic [LaneWidth-1:0] dvs_q;
  logic [LaneWidth-1:0] dvs_eff;
  logic                 next_bit;
  logic [LaneWidth:0]   trial;
  logic [LaneWidth:0]   diff;
  logic                 q_bit;
  logic                 div_zero;
  logic [LaneWidth-1:0] quotient;

  assign narrow = (fmt_i == FMT_W16);

  // --------------------------------------------------
  // Restoring recurrence
  // --------------------------------------------------
  // In FMT_W16 the walk starts at bit 15, so 16 steps finish it
  assign dvs_eff  = narrow ? (dvs_q & LowMask) : dvs_q;
  assign next_bit = narrow ? dvd_q[FMT_W16_BITS-1] : dvd_q[LaneWidth-1];
  assign trial    = {rem_q, next_bit};
  assign q_bit    = (trial >= {1'b0, dvs_eff});
  assign diff     = trial - {1'b0, dvs_eff};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dvd_q <= '0;
      rem_q <= '0;
      dvs_q <= '0;
    end else if (start_i) begin
      dvd_q <= dividend_i;
      rem_q <= '0;
      dvs_q <= divisor_i;
    end else if (step_i) begin
      dvd_q <= {dvd_q[LaneWidth-2:0], q_bit};
      // Keep the subtraction only if it did not go negative
      rem_q <= q_bit ? diff[LaneWidth-1:0] : trial[LaneWidth-1:0];
    end
  end

  // --------------------------------------------------
  // Result and flags
  // --------------------------------------------------
  assign div_zero = (dvs_eff == '0);

  // Zero divisor gives all ones, the remainder already holds the dividend
  always_comb begin
    if (div_zero) begin
      quotient = narrow ? LowMask : '1;
    end else begin
      quotient = narrow ? (dvd_q & LowMask) : dvd_q;
    end
  end

  assign result_o   = (op_i == OP_DIV) ? quotient : rem_q;
  assign flags_o.dz = div_zero;
  assign flags_o.nx = ~div_zero & (rem_q != '0);

endmodule

// File: div_iter_timer.sv
/*
 * Iteration timer of the SIMD divide slice
 * Down-counter loaded with the element width, one step per cycle
 */

`timescale 1ns/100ps

module div_iter_timer (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               load_i,
  input  simd_fmt_pkg::fmt_e fmt_i,
  output logic               step_o,
  output logic               last_o
);

  import simd_fmt_pkg::*;

  logic [ITER_CNT_W-1:0] cnt_q;
  logic [ITER_CNT_W-1:0] load_val;

  // One quotient bit per element bit
  assign load_val = (fmt_i == FMT_W16) ? ITER_CNT_W'(FMT_W16_BITS)
                                       : ITER_CNT_W'(FMT_W32_BITS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= load_val;
    end else if (step_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign step_o = (cnt_q != '0);
  assign last_o = (cnt_q == ITER_CNT_W'(1));

endmodule

// File: divslice_ctrl_fsm.sv
/*
 * Control FSM of the SIMD divide slice
 * Valid/ready handshake, tag and format holding,
 * lane-active capture, lane start and timer load
 */

`timescale 1ns/100ps

module divslice_ctrl_fsm #(
  parameter type TagType = logic [3:0]
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     in_valid_i,
  input  logic                     out_ready_i,
  input  simd_fmt_pkg::fmt_e       fmt_i,
  input  simd_fmt_pkg::op_e        op_i,
  input  logic                     vectorial_op_i,
  input  simd_fmt_pkg::lane_mask_t simd_mask_i,
  input  TagType                   tag_i,
  input  logic                     last_i,
  output logic                     in_ready_o,
  output logic                     out_valid_o,
  output logic                     busy_o,
  output TagType                   tag_o,
  output simd_fmt_pkg::fmt_e       fmt_q_o,
  output simd_fmt_pkg::op_e        op_q_o,
  output simd_fmt_pkg::lane_mask_t mask_q_o,
  output simd_fmt_pkg::lane_mask_t lane_active_o,
  output simd_fmt_pkg::lane_mask_t lane_start_o,
  output logic                     timer_load_o
);

  import simd_fmt_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e     state_q;
  state_e     state_d;
  logic       accept;
  logic       load_q;
  lane_mask_t active_d;
  lane_mask_t active_q;
  TagType     tag_q;
  fmt_e       fmt_q;
  op_e        op_q;
  lane_mask_t mask_q;

  assign accept = in_valid_i & in_ready_o;

  // Lane 0 always works, upper lanes only for vectorial 16-bit ops
  always_comb begin
    for (int unsigned l = 0; l < NUM_LANES; l++) begin
      active_d[l] = (l == 0) || ((fmt_i == FMT_W16) && vectorial_op_i);
    end
  end

  // --------------------------------------------------
  // State transitions
  // --------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (accept) state_d = RUN;
      RUN:  if (last_i) state_d = DONE;
      DONE: if (out_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      load_q   <= 1'b0;
      active_q <= '0;
    end else begin
      state_q <= state_d;
      // Timer starts one cycle after the lanes took their operands
      load_q  <= accept;
      if (accept) begin
        active_q <= active_d;
      end
    end
  end

  // Operation attributes held until the result leaves
  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q  <= tag_i;
      fmt_q  <= fmt_i;
      op_q   <= op_i;
      mask_q <= simd_mask_i;
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign in_ready_o    = (state_q == IDLE);
  assign out_valid_o   = (state_q == DONE);
  assign busy_o        = (state_q != IDLE);
  assign tag_o         = tag_q;
  assign fmt_q_o       = fmt_q;
  assign op_q_o        = op_q;
  assign mask_q_o      = mask_q;
  assign lane_active_o = active_q;
  assign lane_start_o  = {NUM_LANES{accept}} & active_d;
  assign timer_load_o  = load_q;

endmodule

// File: div_flags_pkg.sv
/*
 * Status flags of the integer divide slice
 * Flag struct and the boxing value for unused lanes
 */

package div_flags_pkg;

  // dz  divisor is zero
  // nx  divisor non-zero, remainder non-zero
  typedef struct packed {
    logic dz;
    logic nx;
  } div_flags_t;

  // Upper half of a scalar 16-bit result
  localparam logic [15:0] BOX_FILL = 16'hFFFF;

endpackage

// File: simd_fmt_pkg.sv
/*
 * SIMD format description for the integer divide slice
 * Data width, lane count, format and operation encodings,
 * per-format element widths and the iteration counter width
 */

package simd_fmt_pkg;

  // --------------------------------------------------
  // Datapath geometry
  // --------------------------------------------------
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned NUM_LANES  = 2;

  // Element widths, also the iteration count per format
  localparam int unsigned FMT_W32_BITS = 32;
  localparam int unsigned FMT_W16_BITS = 16;

  // Wide enough to hold the largest iteration count
  localparam int unsigned ITER_CNT_W = 6;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic {
    FMT_W32 = 1'b0,
    FMT_W16 = 1'b1
  } fmt_e;

  typedef enum logic {
    OP_DIV = 1'b0,
    OP_REM = 1'b1
  } op_e;

  // One bit per SIMD lane
  typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage
